// File: source/core_pkg.sv
package core_pkg;

    // source buffer geometry
    // each bank holds pair_depth 64-bit words, split into even and odd halves
    localparam int pair_depth = 1024;
    localparam int pair_aw = 10;

    // half-word read address
    // bit 0 picks odd or even, the upper bits index the pair
    localparam int exec_aw = pair_aw + 1;

    // host write word and read word widths
    localparam int src_dw = 64;
    localparam int word_w = 32;

    // accumulator wide enough for 255 full-scale words
    localparam int acc_w = 42;

    // command fields
    localparam int len_w = 8;
    localparam int op_w = 2;

    // reduction operations
    localparam logic [op_w-1:0] op_sum = 2'd0;
    localparam logic [op_w-1:0] op_max = 2'd1;
    localparam logic [op_w-1:0] op_xor = 2'd2;
    localparam logic [op_w-1:0] op_cnt = 2'd3;

    // result numbering
    localparam int seq_w = 8;

endpackage

// File: source/src_buf.sv
`timescale 1ns/1ps
`default_nettype none

module src_buf (
    input  logic                         clk,
    input  logic                         src_v,
    input  logic [core_pkg::pair_aw-1:0] src_a,
    input  logic [core_pkg::src_dw-1:0]  src_d,
    input  logic                         exec,
    input  logic [core_pkg::exec_aw-1:0] exec_src_addr,
    input  logic                         p,
    output logic [core_pkg::word_w-1:0]  exec_src_data
);

    // p high writes bank 0 and reads bank 1
    // p low writes bank 1 and reads bank 0
    logic [core_pkg::word_w-1:0] bank0_even [core_pkg::pair_depth];
    logic [core_pkg::word_w-1:0] bank0_odd  [core_pkg::pair_depth];
    logic [core_pkg::word_w-1:0] bank1_even [core_pkg::pair_depth];
    logic [core_pkg::word_w-1:0] bank1_odd  [core_pkg::pair_depth];

    logic [core_pkg::pair_aw-1:0] pair_idx;

    assign pair_idx = exec_src_addr[core_pkg::exec_aw-1:1];

    // low half of the host word goes to the even array and high half to the odd one
    always_ff @(posedge clk) begin
        if (src_v && p) begin
            bank0_even[src_a] <= src_d[core_pkg::word_w-1:0];
            bank0_odd[src_a]  <= src_d[core_pkg::src_dw-1:core_pkg::word_w];
        end
    end

    always_ff @(posedge clk) begin
        if (src_v && !p) begin
            bank1_even[src_a] <= src_d[core_pkg::word_w-1:0];
            bank1_odd[src_a]  <= src_d[core_pkg::src_dw-1:core_pkg::word_w];
        end
    end

    // registered read from the bank opposite the write bank
    always_ff @(posedge clk) begin
        if (exec) begin
            case ({p, exec_src_addr[0]})
                2'b00:   exec_src_data <= bank0_even[pair_idx];
                2'b01:   exec_src_data <= bank0_odd[pair_idx];
                2'b10:   exec_src_data <= bank1_even[pair_idx];
                default: exec_src_data <= bank1_odd[pair_idx];
            endcase
        end
    end

    // bank select holds steady while a command issues reads
    a_bank_steady: assert property (
        @(posedge clk) exec |-> $stable(p)
    ) else $error("src_buf: bank select changed during a read run");

endmodule

`default_nettype wire

// File: source/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_v,
    input  logic [core_pkg::op_w-1:0]    cmd_op,
    input  logic [core_pkg::exec_aw-1:0] cmd_base,
    input  logic [core_pkg::len_w-1:0]   cmd_len,
    output logic                         busy,
    output logic                         exec,
    output logic [core_pkg::exec_aw-1:0] exec_src_addr,
    output logic                         rd_v,
    output logic                         rd_first,
    output logic                         rd_last,
    output logic [core_pkg::op_w-1:0]    rd_op
);

    logic [core_pkg::len_w-1:0] remain;
    logic [core_pkg::op_w-1:0]  op_q;
    logic                       first_q;
    logic                       accept;
    logic                       last_issue;

    // zero-length or overlapping strobes are dropped
    assign accept = cmd_v && !busy && (cmd_len != '0);

    // remain stays at 1 or more while busy
    assign last_issue = busy && (remain[core_pkg::len_w-1:1] == '0);

    assign exec = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            first_q <= 1'b0;
        end else if (accept) begin
            busy    <= 1'b1;
            first_q <= 1'b1;
        end else if (busy) begin
            first_q <= 1'b0;
            if (last_issue) begin
                busy <= 1'b0;
            end
        end
    end

    // address walks up one half-word per read
    always_ff @(posedge clk) begin
        if (accept) begin
            exec_src_addr <= cmd_base;
            remain        <= cmd_len;
            op_q          <= cmd_op;
        end else if (busy) begin
            exec_src_addr <= exec_src_addr + 1'b1;
            remain        <= remain - 1'b1;
        end
    end

    // tags trail the read by one cycle to meet the buffer data
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_v     <= 1'b0;
            rd_first <= 1'b0;
            rd_last  <= 1'b0;
        end else begin
            rd_v     <= exec;
            rd_first <= exec && first_q;
            rd_last  <= last_issue;
        end
        rd_op <= op_q;
    end

    // a command must fit below the top of the half-word space
    a_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        (busy && !last_issue) |=> (exec_src_addr > $past(exec_src_addr))
    ) else $error("cmd_decode: read address wrapped within a command");

endmodule

`default_nettype wire

// File: source/reduce_exec.sv
`timescale 1ns/1ps
`default_nettype none

module reduce_exec (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_v,
    input  logic                        rd_first,
    input  logic                        rd_last,
    input  logic [core_pkg::op_w-1:0]   rd_op,
    input  logic [core_pkg::word_w-1:0] exec_src_data,
    output logic                        acc_v,
    output logic [core_pkg::acc_w-1:0]  acc_val,
    output logic [core_pkg::op_w-1:0]   acc_op
);

    logic [core_pkg::acc_w-1:0] acc_in;
    logic [core_pkg::acc_w-1:0] acc_next;

    // one reduction step
    // seeding is the same step applied to an empty accumulator
    function automatic logic [core_pkg::acc_w-1:0] fold(
        input logic [core_pkg::op_w-1:0]   op,
        input logic [core_pkg::acc_w-1:0]  acc,
        input logic [core_pkg::word_w-1:0] word
    );
        logic [core_pkg::acc_w-1:0] wide;
        logic [core_pkg::acc_w-1:0] one_if_set;
        wide = {{(core_pkg::acc_w - core_pkg::word_w){1'b0}}, word};
        one_if_set = {{(core_pkg::acc_w - 1){1'b0}}, (word != '0)};
        case (op)
            core_pkg::op_sum: fold = acc + wide;
            core_pkg::op_max: fold = (wide > acc) ? wide : acc;
            core_pkg::op_xor: fold = acc ^ wide;
            core_pkg::op_cnt: fold = acc + one_if_set;
            default:          fold = acc;
        endcase
    endfunction

    assign acc_in   = rd_first ? '0 : acc_val;
    assign acc_next = fold(rd_op, acc_in, exec_src_data);

    always_ff @(posedge clk) begin
        if (rd_v) begin
            acc_val <= acc_next;
        end
        if (rd_v && rd_last) begin
            acc_op <= rd_op;
        end
    end

    // result is valid the cycle after the last word folds in
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_v <= 1'b0;
        end else begin
            acc_v <= rd_v && rd_last;
        end
    end

    a_first_has_data: assert property (
        @(posedge clk) disable iff (rst) rd_first |-> rd_v
    ) else $error("reduce_exec: first tag without read data");

endmodule

`default_nettype wire

// File: source/result_store.sv
`timescale 1ns/1ps
`default_nettype none

module result_store (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        acc_v,
    input  logic [core_pkg::acc_w-1:0]  acc_val,
    input  logic [core_pkg::op_w-1:0]   acc_op,
    output logic                        res_v,
    output logic [core_pkg::word_w-1:0] res_data,
    output logic [core_pkg::op_w-1:0]   res_op,
    output logic                        res_sat,
    output logic [core_pkg::seq_w-1:0]  res_seq
);

    logic [core_pkg::seq_w-1:0] next_seq;
    logic                       over;

    // anything above the low word means the sum left 32 bits
    assign over = (acc_val[core_pkg::acc_w-1:core_pkg::word_w] != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            res_v    <= 1'b0;
            res_sat  <= 1'b0;
            res_seq  <= '0;
            next_seq <= '0;
        end else begin
            res_v <= acc_v;
            if (acc_v) begin
                res_sat  <= over;
                res_seq  <= next_seq;
                next_seq <= next_seq + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_v) begin
            res_data <= over ? '1 : acc_val[core_pkg::word_w-1:0];
            res_op   <= acc_op;
        end
    end

    // only a sum can outgrow the result word
    a_sat_only_sum: assert property (
        @(posedge clk) disable iff (rst) (res_v && res_sat) |-> (res_op == core_pkg::op_sum)
    ) else $error("result_store: saturation on a non-sum result");

endmodule

`default_nettype wire

// File: source/reduce_core.sv
`timescale 1ns/1ps
`default_nettype none

module reduce_core (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         src_v,
    input  logic [core_pkg::pair_aw-1:0] src_a,
    input  logic [core_pkg::src_dw-1:0]  src_d,
    input  logic                         p,
    input  logic                         cmd_v,
    input  logic [core_pkg::op_w-1:0]    cmd_op,
    input  logic [core_pkg::exec_aw-1:0] cmd_base,
    input  logic [core_pkg::len_w-1:0]   cmd_len,
    output logic                         busy,
    output logic                         res_v,
    output logic [core_pkg::word_w-1:0]  res_data,
    output logic [core_pkg::op_w-1:0]    res_op,
    output logic                         res_sat,
    output logic [core_pkg::seq_w-1:0]   res_seq
);

    logic                         exec;
    logic [core_pkg::exec_aw-1:0] exec_src_addr;
    logic [core_pkg::word_w-1:0]  exec_src_data;
    logic                         rd_v;
    logic                         rd_first;
    logic                         rd_last;
    logic [core_pkg::op_w-1:0]    rd_op;
    logic                         acc_v;
    logic [core_pkg::acc_w-1:0]   acc_val;
    logic [core_pkg::op_w-1:0]    acc_op;

    src_buf u_src_buf (
        .clk(clk), .src_v(src_v), .src_a(src_a), .src_d(src_d),
        .exec(exec), .exec_src_addr(exec_src_addr), .p(p),
        .exec_src_data(exec_src_data)
    );

    cmd_decode u_cmd_decode (
        .clk(clk), .rst(rst), .cmd_v(cmd_v), .cmd_op(cmd_op),
        .cmd_base(cmd_base), .cmd_len(cmd_len), .busy(busy), .exec(exec),
        .exec_src_addr(exec_src_addr), .rd_v(rd_v), .rd_first(rd_first),
        .rd_last(rd_last), .rd_op(rd_op)
    );

    reduce_exec u_reduce_exec (
        .clk(clk), .rst(rst), .rd_v(rd_v), .rd_first(rd_first),
        .rd_last(rd_last), .rd_op(rd_op), .exec_src_data(exec_src_data),
        .acc_v(acc_v), .acc_val(acc_val), .acc_op(acc_op)
    );

    result_store u_result_store (
        .clk(clk), .rst(rst), .acc_v(acc_v), .acc_val(acc_val),
        .acc_op(acc_op), .res_v(res_v), .res_data(res_data),
        .res_op(res_op), .res_sat(res_sat), .res_seq(res_seq)
    );

endmodule

`default_nettype wire

// File: test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held over two rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: test/tb_reduce_core.sv
`timescale 1ns/1ps

module tb_reduce_core;

    localparam int n_rows = 11;
    localparam int res_timeout = 400;

    logic                         clk;
    logic                         rst;
    logic                         src_v;
    logic [core_pkg::pair_aw-1:0] src_a;
    logic [core_pkg::src_dw-1:0]  src_d;
    logic                         p;
    logic                         cmd_v;
    logic [core_pkg::op_w-1:0]    cmd_op;
    logic [core_pkg::exec_aw-1:0] cmd_base;
    logic [core_pkg::len_w-1:0]   cmd_len;
    logic                         busy;
    logic                         res_v;
    logic [core_pkg::word_w-1:0]  res_data;
    logic [core_pkg::op_w-1:0]    res_op;
    logic                         res_sat;
    logic [core_pkg::seq_w-1:0]   res_seq;

    // one command per row, expected columns come from the model
    string                        row_name [n_rows];
    logic                         row_p    [n_rows];
    logic [core_pkg::op_w-1:0]    row_op   [n_rows];
    logic [core_pkg::exec_aw-1:0] row_base [n_rows];
    logic [core_pkg::len_w-1:0]   row_len  [n_rows];
    logic [core_pkg::word_w-1:0]  row_exp  [n_rows];
    logic                         row_sat  [n_rows];

    // reference banks by half-word address
    logic [core_pkg::word_w-1:0] model_mem [2][2 * core_pkg::pair_depth];
    logic [core_pkg::seq_w-1:0]  exp_seq;
    logic [core_pkg::seq_w-1:0]  res_count;
    integer                      seed;
    int                          errors;

    clk_gen u_clk_gen (.clk(clk), .rst(rst));

    reduce_core u_reduce_core (.*);

    // every result strobe the DUT emits
    always @(posedge clk) begin
        if (rst) begin
            res_count <= '0;
        end else if (res_v) begin
            res_count <= res_count + 1'b1;
        end
    end

    task automatic check_word(input string name, input logic [core_pkg::word_w-1:0] exp, act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_op(input string name, input logic [core_pkg::op_w-1:0] exp, act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected op %0d, actual op %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_seq(input string name, input logic [core_pkg::seq_w-1:0] exp, act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, act);
        if (act != exp) begin
            $display("CHECK FAILED %s latency: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_row(input int i, input string name, input logic pv,
                           input logic [core_pkg::op_w-1:0] op, input int base, input int len);
        row_name[i] = name;
        row_p[i]    = pv;
        row_op[i]   = op;
        row_base[i] = base[core_pkg::exec_aw-1:0];
        row_len[i]  = len[core_pkg::len_w-1:0];
    endtask

    task automatic fill_model();
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < 2 * core_pkg::pair_depth; a++) begin
                // all ones run for saturation
                if (a >= 200 && a < 240) begin
                    model_mem[b][a] = '1;
                end else if ((a >= 400 && a < 432) || (a % 11 == 5)) begin
                    model_mem[b][a] = '0;
                end else if (a >= 600 && a < 680) begin
                    model_mem[b][a] = 32'(a * 7 + b);
                end else begin
                    model_mem[b][a] = $random(seed);
                end
            end
        end
    endtask

    // reduction straight from the operation rules, p high reads bank 1
    task automatic expect_row(input int i);
        longint unsigned             acc;
        logic [core_pkg::word_w-1:0] w;
        acc = 0;
        for (int k = 0; k < int'(row_len[i]); k++) begin
            w = model_mem[row_p[i]][int'(row_base[i]) + k];
            case (row_op[i])
                core_pkg::op_sum: acc = acc + w;
                core_pkg::op_max: acc = (w > acc) ? w : acc;
                core_pkg::op_xor: acc = acc ^ w;
                default:          acc = acc + (w != '0);
            endcase
        end
        row_sat[i] = (acc > 64'hffff_ffff);
        row_exp[i] = row_sat[i] ? '1 : acc[31:0];
    endtask

    task automatic load_bank(input int b);
        for (int a = 0; a < core_pkg::pair_depth; a++) begin
            src_v = 1'b1;
            src_a = a[core_pkg::pair_aw-1:0];
            src_d = {model_mem[b][2 * a + 1], model_mem[b][2 * a]};
            next_cycle();
        end
        src_v = 1'b0;
    endtask

    // strobe is sampled at the next edge, returns in cycle 1
    task automatic drive_cmd(input int i, input logic [core_pkg::len_w-1:0] len);
        p        = row_p[i];
        cmd_v    = 1'b1;
        cmd_op   = row_op[i];
        cmd_base = row_base[i];
        cmd_len  = len;
        next_cycle();
        cmd_v = 1'b0;
    endtask

    // cyc holds the cycle number counted from the command's cycle 0
    task automatic collect_result(input int i, inout int cyc);
        int n;
        n = 0;
        while (!res_v && n < res_timeout) begin
            next_cycle();
            cyc++;
            n++;
        end
        if (!res_v) begin
            $display("%s: result strobe did not arrive in time", row_name[i]);
            errors++;
        end else begin
            check_latency(row_name[i], int'(row_len[i]) + 3, cyc);
            check_word(row_name[i], row_exp[i], res_data);
            check_op(row_name[i], row_op[i], res_op);
            check_flag({row_name[i], "_sat"}, row_sat[i], res_sat);
            check_seq({row_name[i], "_seq"}, exp_seq, res_seq);
        end
        exp_seq++;
        next_cycle();
        cyc++;
    endtask

    task automatic run_row(input int i);
        int cyc;
        check_flag({row_name[i], "_idle"}, 1'b0, busy);
        drive_cmd(i, row_len[i]);
        cyc = 1;
        collect_result(i, cyc);
    endtask

    // a strobe while busy and a zero length strobe are both dropped
    task automatic run_dropped(input int i, input int other);
        int cyc;
        drive_cmd(i, row_len[i]);
        next_cycle();
        drive_cmd(other, row_len[other]);
        cyc = 3;
        collect_result(i, cyc);
        drive_cmd(other, '0);
        check_flag("zero_len_busy", 1'b0, busy);
        repeat (40) next_cycle();
    endtask

    // second command lands in the first cycle after busy drops
    task automatic run_back_to_back(input int a, input int b);
        int cyc;
        drive_cmd(a, row_len[a]);
        cyc = 1;
        repeat (row_len[a]) begin
            next_cycle();
            cyc++;
        end
        check_flag("back_to_back_idle", 1'b0, busy);
        drive_cmd(b, row_len[b]);
        cyc++;
        collect_result(a, cyc);
        cyc = cyc - int'(row_len[a]) - 1;
        collect_result(b, cyc);
    endtask

    initial begin
        int n;
        seed     = 92;
        errors   = 0;
        exp_seq  = '0;
        src_v    = 1'b0;
        src_a    = '0;
        src_d    = '0;
        p        = 1'b1;
        cmd_v    = 1'b0;
        cmd_op   = '0;
        cmd_base = '0;
        cmd_len  = '0;

        set_row(0,  "pp_xor_bank0", 1'b0, core_pkg::op_xor, 1201, 9);
        set_row(1,  "pp_xor_bank1", 1'b1, core_pkg::op_xor, 1201, 9);
        set_row(2,  "sum_small",    1'b1, core_pkg::op_sum, 600,  40);
        set_row(3,  "sum_sat",      1'b1, core_pkg::op_sum, 200,  20);
        set_row(4,  "sum_single",   1'b0, core_pkg::op_sum, 1001, 1);
        set_row(5,  "max_odd",      1'b0, core_pkg::op_max, 77,   33);
        set_row(6,  "max_even",     1'b1, core_pkg::op_max, 1500, 200);
        set_row(7,  "xor_long",     1'b0, core_pkg::op_xor, 2,    255);
        set_row(8,  "cnt_zeros",    1'b0, core_pkg::op_cnt, 399,  40);
        set_row(9,  "cnt_odd",      1'b1, core_pkg::op_cnt, 1801, 100);
        set_row(10, "sum_top",      1'b0, core_pkg::op_sum, 1990, 58);
        fill_model();
        for (int i = 0; i < n_rows; i++) begin
            expect_row(i);
        end

        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            next_cycle();
            n++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            errors++;
        end
        check_flag("reset_busy", 1'b0, busy);
        check_flag("reset_res_v", 1'b0, res_v);

        // p high fills bank 0, then p low reads it while bank 1 fills
        load_bank(0);
        p = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            if (i == 0) begin
                fork
                    load_bank(1);
                    run_row(0);
                join
            end else begin
                run_row(i);
            end
        end
        run_dropped(8, 4);
        run_back_to_back(5, 8);
        check_seq("result_count", exp_seq, res_count);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: build.f
source/core_pkg.sv
source/src_buf.sv
source/cmd_decode.sv
source/reduce_exec.sv
source/result_store.sv
source/reduce_core.sv
test/clk_gen.sv
test/tb_reduce_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_reduce_core \
    -f build.f -o sim_tb || exit 1
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
